/* logic/noc_pkg.sv */
// packet-side definitions for the one-row slice; only x coordinates exist, no y dimension
package noc_pkg;

  // tiles in the row
  localparam int NUM_TILES = 4;

  // wide enough to also name coordinates with no tile behind them
  localparam int X_CORD_W = 3;

  // stray packet counter at the east edge, saturating
  localparam int STRAY_CNT_W = 8;

  typedef logic [X_CORD_W-1:0] x_cord_t;

  typedef logic [STRAY_CNT_W-1:0] stray_cnt_t;

  // store hands back the word it overwrote
  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } noc_op_e;

endpackage

/* logic/tile_pkg.sv */
// tile memory definitions; MEM_WORDS must stay a power of two to match MEM_ADDR_W
package tile_pkg;

  localparam int WORD_W = 32;

  localparam int MEM_WORDS = 16;  // words per tile

  localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

  typedef logic [WORD_W-1:0] word_t;

  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

endpackage

/* logic/noc_link_if.sv */
// one packet per cycle when v is high; no ready, so the receiver must take it that cycle
`timescale 1ns/1ps

interface noc_link_if import noc_pkg::*, tile_pkg::*; ();

  logic      v;     // valid strobe
  noc_op_e   op;
  x_cord_t   x;     // destination on requests, responder on responses
  mem_addr_t addr;
  word_t     data;

  modport tx (
    output v,
    output op,
    output x,
    output addr,
    output data
  );

  modport rx (
    input v,
    input op,
    input x,
    input addr,
    input data
  );

endinterface

/* logic/tile_mem.sv */
// per-tile word memory; read path is combinational, so the old word is visible on a store
`timescale 1ns/1ps

module tile_mem import noc_pkg::*, tile_pkg::*; (
  input  logic      clk,
  input  logic      arst_n_i,
  input  logic      eject_i,
  input  noc_op_e   op_i,
  input  mem_addr_t addr_i,
  input  word_t     data_i,
  output word_t     rdata_o
);

  word_t mem [MEM_WORDS];
  logic  wr_en;

  assign wr_en = eject_i && (op_i == OP_STORE);

  // memory is cleared so every tile reads zero after reset
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[addr_i] <= data_i;
    end
  end

  // load data, or the replaced word on a store
  assign rdata_o = mem[addr_i];

  a_legal_op: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    eject_i |-> (op_i inside {OP_LOAD, OP_STORE})
  );

endmodule

/* logic/row_router.sv */
// one hop per cycle on both lanes; relies on fixed latency, there is no stall path
`timescale 1ns/1ps

module row_router import noc_pkg::*, tile_pkg::*; (
  input  logic      clk,
  input  logic      arst_n_i,
  input  x_cord_t   my_x_i,
  noc_link_if.rx    req_in,
  noc_link_if.rx    rsp_in,
  noc_link_if.tx    req_out,
  noc_link_if.tx    rsp_out,
  output logic      eject_o,
  output noc_op_e   eject_op_o,
  output mem_addr_t eject_addr_o,
  output word_t     eject_data_o,
  input  word_t     local_data_i
);

  logic hit;
  logic fwd;

  logic      req_v_q;
  noc_op_e   req_op_q;
  x_cord_t   req_x_q;
  mem_addr_t req_addr_q;
  word_t     req_data_q;

  logic      rsp_v_q;
  noc_op_e   rsp_op_q;
  x_cord_t   rsp_x_q;
  mem_addr_t rsp_addr_q;
  word_t     rsp_data_q;

  assign hit = req_in.v && (req_in.x == my_x_i);
  assign fwd = req_in.v && !hit;

  // eject side goes straight to the tile memory
  assign eject_o      = hit;
  assign eject_op_o   = req_in.op;
  assign eject_addr_o = req_in.addr;
  assign eject_data_o = req_in.data;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_v_q <= 1'b0;
      rsp_v_q <= 1'b0;
    end else begin
      req_v_q <= fwd;
      rsp_v_q <= hit || rsp_in.v;
    end
  end

  always_ff @(posedge clk) begin
    if (fwd) begin
      req_op_q   <= req_in.op;
      req_x_q    <= req_in.x;
      req_addr_q <= req_in.addr;
      req_data_q <= req_in.data;
    end
  end

  // local response takes the slot of a passing one
  always_ff @(posedge clk) begin
    if (hit) begin
      rsp_op_q   <= req_in.op;
      rsp_x_q    <= my_x_i;
      rsp_addr_q <= req_in.addr;
      rsp_data_q <= local_data_i;  // word before the store lands
    end else if (rsp_in.v) begin
      rsp_op_q   <= rsp_in.op;
      rsp_x_q    <= rsp_in.x;
      rsp_addr_q <= rsp_in.addr;
      rsp_data_q <= rsp_in.data;
    end
  end

  assign req_out.v    = req_v_q;
  assign req_out.op   = req_op_q;
  assign req_out.x    = req_x_q;
  assign req_out.addr = req_addr_q;
  assign req_out.data = req_data_q;

  assign rsp_out.v    = rsp_v_q;
  assign rsp_out.op   = rsp_op_q;
  assign rsp_out.x    = rsp_x_q;
  assign rsp_out.addr = rsp_addr_q;
  assign rsp_out.data = rsp_data_q;

  // an upstream response always comes from another injection cycle than a local hit
  a_no_collide: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    !(hit && rsp_in.v)
  );

  // no router further west let its own packet through
  a_no_leak: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    req_in.v |-> (req_in.x >= my_x_i)
  );

endmodule

/* logic/edge_sink.sv */
// east end of the request lane; stray count saturates at all ones and is never cleared but by reset
`timescale 1ns/1ps

module edge_sink import noc_pkg::*; (
  input  logic       clk,
  input  logic       arst_n_i,
  noc_link_if.rx     req_in,
  output logic       stray_o,
  output stray_cnt_t stray_count_o
);

  stray_cnt_t cnt_q;

  assign stray_o = req_in.v;  // same cycle as arrival

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (req_in.v && (cnt_q != '1)) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign stray_count_o = cnt_q;

  // anything reaching here was addressed past the row, so no router missed its own packet
  a_only_strays: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    req_in.v |-> (req_in.x >= x_cord_t'(NUM_TILES))
  );

endmodule

/* logic/noc_row_top.sv */
// responses leave NUM_TILES cycles after the request in request order; no flow control on any port
`timescale 1ns/1ps

module noc_row_top import noc_pkg::*, tile_pkg::*; (
  input  logic       clk,
  input  logic       arst_n_i,
  input  logic       req_v_i,
  input  noc_op_e    req_op_i,
  input  x_cord_t    req_x_i,
  input  mem_addr_t  req_addr_i,
  input  word_t      req_data_i,
  output logic       rsp_v_o,
  output noc_op_e    rsp_op_o,
  output x_cord_t    rsp_x_o,
  output mem_addr_t  rsp_addr_o,
  output word_t      rsp_data_o,
  output logic       stray_o,
  output stray_cnt_t stray_count_o
);

  noc_link_if req_link [NUM_TILES+1] ();
  noc_link_if rsp_link [NUM_TILES+1] ();

  // west end of the request lane
  assign req_link[0].v    = req_v_i;
  assign req_link[0].op   = req_op_i;
  assign req_link[0].x    = req_x_i;
  assign req_link[0].addr = req_addr_i;
  assign req_link[0].data = req_data_i;

  // nothing enters the response lane from the west
  assign rsp_link[0].v    = 1'b0;
  assign rsp_link[0].op   = OP_LOAD;
  assign rsp_link[0].x    = '0;
  assign rsp_link[0].addr = '0;
  assign rsp_link[0].data = '0;

  for (genvar k = 0; k < NUM_TILES; k++) begin : g_tile
    logic      eject;
    noc_op_e   eject_op;
    mem_addr_t eject_addr;
    word_t     eject_data;
    word_t     local_data;

    row_router u_router (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .my_x_i       (x_cord_t'(k)),
      .req_in       (req_link[k]),
      .rsp_in       (rsp_link[k]),
      .req_out      (req_link[k+1]),
      .rsp_out      (rsp_link[k+1]),
      .eject_o      (eject),
      .eject_op_o   (eject_op),
      .eject_addr_o (eject_addr),
      .eject_data_o (eject_data),
      .local_data_i (local_data)
    );

    tile_mem u_mem (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .eject_i  (eject),
      .op_i     (eject_op),
      .addr_i   (eject_addr),
      .data_i   (eject_data),
      .rdata_o  (local_data)
    );
  end

  edge_sink u_sink (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .req_in        (req_link[NUM_TILES]),
    .stray_o       (stray_o),
    .stray_count_o (stray_count_o)
  );

  // east end of the response lane
  assign rsp_v_o    = rsp_link[NUM_TILES].v;
  assign rsp_op_o   = rsp_link[NUM_TILES].op;
  assign rsp_x_o    = rsp_link[NUM_TILES].x;
  assign rsp_addr_o = rsp_link[NUM_TILES].addr;
  assign rsp_data_o = rsp_link[NUM_TILES].data;

endmodule

/* verif/tb_noc_row.sv */
// expects 4 tiles of 16 words; table nibbles limit x and addr to 15 and tests to 15
`timescale 1ns/1ps

module tb_noc_row import noc_pkg::*, tile_pkg::*; ();

  localparam int TABLE_LEN    = 43;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_TESTS    = 5;

  localparam logic [1:0] EXP_RSP   = 2'd1;
  localparam logic [1:0] EXP_STRAY = 2'd2;

  typedef struct packed {
    int         due;   // cycle count at which the outcome is sampled
    logic [3:0] test;
    logic       last;  // final entry of its test
    logic [1:0] kind;
    noc_op_e    op;
    x_cord_t    x;
    mem_addr_t  addr;
    word_t      data;
  } expect_t;

  logic       clk;
  logic       arst_n_i;
  logic       req_v_i;
  noc_op_e    req_op_i;
  x_cord_t    req_x_i;
  mem_addr_t  req_addr_i;
  word_t      req_data_i;
  logic       rsp_v_o;
  noc_op_e    rsp_op_o;
  x_cord_t    rsp_x_o;
  mem_addr_t  rsp_addr_o;
  word_t      rsp_data_o;
  logic       stray_o;
  stray_cnt_t stray_count_o;

  logic [23:0] stim [TABLE_LEN];
  word_t       ref_mem [NUM_TILES][MEM_WORDS];
  expect_t     exp_q [$];
  integer      seed;
  int          cyc_q = 0;
  int          cur_test = 1;
  int          ref_strays = 0;
  int          err_count = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          test_errs [0:NUM_TESTS];

  noc_row_top dut0 (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .req_v_i       (req_v_i),
    .req_op_i      (req_op_i),
    .req_x_i       (req_x_i),
    .req_addr_i    (req_addr_i),
    .req_data_i    (req_data_i),
    .rsp_v_o       (rsp_v_o),
    .rsp_op_o      (rsp_op_o),
    .rsp_x_o       (rsp_x_o),
    .rsp_addr_o    (rsp_addr_o),
    .rsp_data_o    (rsp_data_o),
    .stray_o       (stray_o),
    .stray_count_o (stray_count_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cyc_q <= cyc_q + 1;

  function automatic string test_title(input int t);
    case (t)
      1: return "loads after reset";
      2: return "store returns old word";
      3: return "back-to-back ordering";
      4: return "strays past the row";
      5: return "strays mixed with traffic";
      default: return "unknown";
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
      test_errs[cur_test]++;
      err_count++;
    end
  endtask

  task automatic check_event(input expect_t e);
    compare("rsp_v_o", rsp_v_o, (e.kind == EXP_RSP));
    compare("stray_o", stray_o, (e.kind == EXP_STRAY));
    if (e.kind == EXP_RSP) begin
      compare("rsp_op_o", rsp_op_o, e.op);
      compare("rsp_x_o", rsp_x_o, e.x);
      compare("rsp_addr_o", rsp_addr_o, e.addr);
      compare("rsp_data_o", rsp_data_o, e.data);
    end
  endtask

  task automatic report_test(input int t);
    if (test_errs[t] == 0) begin
      tests_passed++;
      $display("test %0d %s: passed", t, test_title(t));
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", t, test_title(t), test_errs[t]);
    end
  endtask

  // outputs are sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin : check_outputs
    expect_t e;
    logic    popped;
    popped = 1'b0;
    if (arst_n_i) begin
      if (exp_q.size() != 0 && exp_q[0].due == cyc_q) begin
        e = exp_q.pop_front();
        popped = 1'b1;
        cur_test = e.test;
        check_event(e);
      end else begin
        compare("rsp_v_o", rsp_v_o, 1'b0);  // nothing due this cycle
        compare("stray_o", stray_o, 1'b0);
      end
      compare("stray_count_o", stray_count_o, ref_strays);
      if (popped && (e.kind == EXP_STRAY)) ref_strays++;  // counter moves on the next edge
      if (popped && e.last) report_test(e.test);
    end
  end

  // counted from reset release
  initial begin : watchdog
    @(posedge arst_n_i);
    repeat (TABLE_LEN + NUM_TILES + 20) @(posedge clk);
    $display("pipeline hung: %0d responses never came out", exp_q.size());
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : run_table
    logic [23:0] row;
    expect_t     e;
    word_t       wdata;
    x_cord_t     x;
    mem_addr_t   a;
    seed = 71759;
    // columns: test, valid, op (1 store), x, addr, expect (0 none, 1 response, 2 stray)
    stim = '{
      24'h1_1_0_0_0_1, 24'h1_1_0_1_0_1, 24'h1_0_0_0_0_0, 24'h1_1_0_2_9_1, 24'h1_1_0_3_F_1,
      24'h1_0_0_0_0_0, 24'h1_1_0_0_F_1, 24'h1_1_0_3_0_1, 24'h1_1_0_2_5_1, 24'h1_1_0_1_A_1,
      24'h2_1_1_1_3_1, 24'h2_1_0_1_3_1, 24'h2_1_0_2_3_1, 24'h2_1_1_1_3_1, 24'h2_0_0_0_0_0,
      24'h2_1_1_2_3_1, 24'h2_1_0_1_3_1, 24'h2_1_0_2_3_1, 24'h2_1_1_0_7_1, 24'h2_1_0_0_7_1,
      24'h3_1_1_3_4_1, 24'h3_1_1_0_4_1, 24'h3_1_1_2_4_1, 24'h3_1_1_1_4_1,
      24'h3_1_0_3_4_1, 24'h3_1_0_0_4_1, 24'h3_1_0_2_4_1, 24'h3_1_0_1_4_1,
      24'h4_1_1_4_2_2, 24'h4_0_0_0_0_0, 24'h4_1_0_5_2_2, 24'h4_1_1_6_8_2, 24'h4_0_0_0_0_0,
      24'h4_1_0_7_1_2,
      24'h5_1_1_2_6_1, 24'h5_1_1_6_6_2, 24'h5_1_0_2_6_1, 24'h5_1_1_4_3_2, 24'h5_1_0_0_3_1,
      24'h5_1_1_5_4_2, 24'h5_1_0_1_4_1, 24'h5_1_1_7_4_2, 24'h5_1_0_3_4_1
    };
    for (int t = 0; t < NUM_TILES; t++) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        ref_mem[t][w] = '0;
      end
    end
    for (int t = 0; t <= NUM_TESTS; t++) begin
      test_errs[t] = 0;
    end
    req_v_i    = 1'b0;
    req_op_i   = OP_LOAD;
    req_x_i    = '0;
    req_addr_i = '0;
    req_data_i = '0;
    arst_n_i   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n_i <= 1'b1;
    for (int i = 0; i < TABLE_LEN; i++) begin
      @(posedge clk);
      row   = stim[i];
      wdata = $random(seed);
      x     = x_cord_t'(row[11:8]);
      a     = mem_addr_t'(row[7:4]);
      req_v_i    <= row[16];
      req_op_i   <= noc_op_e'(row[12]);
      req_x_i    <= x;
      req_addr_i <= a;
      req_data_i <= wdata;
      e.due  = cyc_q + NUM_TILES + 1;  // one edge to enter, NUM_TILES hops
      e.test = row[23:20];
      e.last = (i == TABLE_LEN - 1) || (stim[i+1][23:20] != row[23:20]);
      e.kind = row[1:0];
      e.op   = noc_op_e'(row[12]);
      e.x    = x;
      e.addr = a;
      e.data = '0;
      if (e.kind == EXP_RSP) begin
        e.data = ref_mem[x][a];  // old word on a store
        if (e.op == OP_STORE) ref_mem[x][a] = wdata;
      end
      exp_q.push_back(e);
    end
    @(posedge clk);
    req_v_i <= 1'b0;
    wait (exp_q.size() == 0);
    @(posedge clk);
    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             tests_passed, tests_failed, err_count);
    if (err_count == 0 && tests_passed == NUM_TESTS) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sources.f */
logic/noc_pkg.sv
logic/tile_pkg.sv
logic/noc_link_if.sv
logic/tile_mem.sv
logic/row_router.sv
logic/edge_sink.sv
logic/noc_row_top.sv
verif/tb_noc_row.sv

/* Bender.yml */
package:
  name: noc_row

dependencies: {}

sources:
  - files:
      - logic/noc_pkg.sv
      - logic/tile_pkg.sv
      - logic/noc_link_if.sv
      - logic/tile_mem.sv
      - logic/row_router.sv
      - logic/edge_sink.sv
      - logic/noc_row_top.sv

  - target: test
    files:
      - verif/tb_noc_row.sv
